// File: compile.f
+incdir+design
design/beam_pkg.sv
design/i2s_recorder.sv
design/ring_buffer.sv
design/power_scanner.sv
design/beam_top.sv
test/tb_beam_top.sv

// File: design/beam_cfg.svh
////////////////////////////////////////
// Beam front end configuration constants.
////////////////////////////////////////
`ifndef BEAM_CFG_SVH
`define BEAM_CFG_SVH

// audio word width, left-justified MSB first.
`define SAMPLE_BITS 24

// one frame of left samples, scanned as delayed windows.
`define FRAME_LEN   85
`define WIN_LEN     32

// delays run 0, 7, ... 49, so 49 + 32 stays inside the frame.
`define DELTA_STEP  7
`define N_DIR       8
`define DELTA_BITS  6

`define POWER_BITS  32

`endif

// File: design/beam_pkg.sv
////////////////////////////////////////
// Shared types for the beam front end.
////////////////////////////////////////
`default_nettype none

`include "beam_cfg.svh"

package beam_pkg;

    // One audio sample with its one-cycle strobe.
    typedef struct packed {
        logic                           valid;
        logic signed [`SAMPLE_BITS-1:0] data;
    } pcm_sample_t;

    // Power figure for one steering delay.
    typedef struct packed {
        logic [`DELTA_BITS-1:0] delta;
        logic [`POWER_BITS-1:0] power;
    } scan_result_t;

endpackage

`default_nettype wire

// File: design/beam_top.sv
////////////////////////////////////////
// Direction finder front end top level.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "beam_cfg.svh"

module beam_top (
    input  logic                   i_50M_clk,
    input  logic                   i_rst,
    input  logic                   i_start,
    input  logic                   i_bclk,
    input  logic                   i_lrck,
    input  logic                   i_sdata,
    output beam_pkg::scan_result_t o_result,
    output logic                   o_result_valid,
    output logic                   o_frame_done,
    output logic                   o_frame_ready
);

    import beam_pkg::*;

    pcm_sample_t                    sample;
    logic signed [`SAMPLE_BITS-1:0] read_data;
    logic [`DELTA_BITS-1:0]         delta;
    logic                           advance;
    logic                           rewind;
    logic                           scan_done;

    i2s_recorder u_recorder (
        .i_50M_clk (i_50M_clk),
        .i_rst     (i_rst),
        .i_start   (i_start),
        .i_bclk    (i_bclk),
        .i_lrck    (i_lrck),
        .i_sdata   (i_sdata),
        .o_sample  (sample)
    );

    ring_buffer u_buffer (
        .i_50M_clk     (i_50M_clk),
        .i_rst         (i_rst),
        .i_sample      (sample),
        .i_delta       (delta),
        .i_advance     (advance),
        .i_rewind      (rewind),
        .i_scan_done   (scan_done),
        .o_read_data   (read_data),
        .o_frame_ready (o_frame_ready)
    );

    power_scanner u_scanner (
        .i_50M_clk      (i_50M_clk),
        .i_rst          (i_rst),
        .i_frame_ready  (o_frame_ready),
        .i_read_data    (read_data),
        .o_delta        (delta),
        .o_advance      (advance),
        .o_rewind       (rewind),
        .o_scan_done    (scan_done),
        .o_result       (o_result),
        .o_result_valid (o_result_valid),
        .o_frame_done   (o_frame_done)
    );

endmodule

`default_nettype wire

// File: design/i2s_recorder.sv
////////////////////////////////////////
// I2S recorder: serial audio to left samples.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "beam_cfg.svh"

module i2s_recorder (
    input  logic                  i_50M_clk,
    input  logic                  i_rst,
    input  logic                  i_start,
    input  logic                  i_bclk,
    input  logic                  i_lrck,
    input  logic                  i_sdata,
    output beam_pkg::pcm_sample_t o_sample
);

    localparam int CNT_W = $clog2(`SAMPLE_BITS + 1);

    logic [2:0]              bclk_sync;
    logic [2:0]              lrck_sync;
    logic [1:0]              sdata_sync;
    logic                    bclk_rise;
    logic                    lrck_edge;
    logic [CNT_W-1:0]        bit_cnt;
    logic                    is_right;
    logic                    started;
    logic                    valid_q;
    logic [`SAMPLE_BITS-1:0] shift_q;

    // stages 0 and 1 synchronize, stage 2 only feeds the edge detect.
    // lrck presets high so a low idle level still arms the first left word.
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            bclk_sync  <= '0;
            lrck_sync  <= '1;
            sdata_sync <= '0;
        end else begin
            bclk_sync  <= {bclk_sync[1:0], i_bclk};
            lrck_sync  <= {lrck_sync[1:0], i_lrck};
            sdata_sync <= {sdata_sync[0], i_sdata};
        end
    end

    assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
    assign lrck_edge = lrck_sync[1] ^ lrck_sync[2];

    // The counter parks at SAMPLE_BITS, so extra bit clocks fall through.
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            bit_cnt  <= CNT_W'(`SAMPLE_BITS);
            is_right <= 1'b1;
            started  <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (i_start) begin
                started <= 1'b1;
            end
            if (lrck_edge) begin
                is_right <= lrck_sync[1];
                bit_cnt  <= '0;
            end else if (bclk_rise && bit_cnt != CNT_W'(`SAMPLE_BITS)) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(`SAMPLE_BITS - 1) && !is_right && started) begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_50M_clk) begin
        if (bclk_rise) begin
            shift_q <= {shift_q[`SAMPLE_BITS-2:0], sdata_sync[1]};
        end
    end

    // shift_q holds the finished word during the strobe cycle.
    assign o_sample.valid = valid_q;
    assign o_sample.data  = shift_q;

    // words are many bit clocks apart.
    a_single_strobe: assert property (
        @(posedge i_50M_clk) disable iff (i_rst) valid_q |=> !valid_q
    );

endmodule

`default_nettype wire

// File: design/power_scanner.sv
////////////////////////////////////////
// Steered power scan over a stored frame.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "beam_cfg.svh"

module power_scanner (
    input  logic                           i_50M_clk,
    input  logic                           i_rst,
    input  logic                           i_frame_ready,
    input  logic signed [`SAMPLE_BITS-1:0] i_read_data,
    output logic [`DELTA_BITS-1:0]         o_delta,
    output logic                           o_advance,
    output logic                           o_rewind,
    output logic                           o_scan_done,
    output beam_pkg::scan_result_t         o_result,
    output logic                           o_result_valid,
    output logic                           o_frame_done
);

    import beam_pkg::*;

    localparam int DIR_W = $clog2(`N_DIR);
    localparam int WIN_W = $clog2(`WIN_LEN);

    typedef enum logic [2:0] {
        S_WAIT,
        S_SETUP,
        S_ACCUM,
        S_EMIT,
        S_DONE
    } scan_state_t;

    scan_state_t             state_q;
    logic [DIR_W-1:0]        dir_q;
    logic [WIN_W-1:0]        sample_q;
    logic                    phase_q;
    logic [`POWER_BITS-1:0]  acc_q;
    logic                    scan_done_q;
    logic [`SAMPLE_BITS-1:0] mag;
    logic                    last_dir;
    logic                    last_sample;
    scan_result_t            result_q;

    // unsigned magnitude, so full-scale negative gives 2^23.
    assign mag = i_read_data[`SAMPLE_BITS-1] ? (~i_read_data + 1'b1) : i_read_data;

    assign last_dir    = (dir_q == DIR_W'(`N_DIR - 1));
    assign last_sample = (sample_q == WIN_W'(`WIN_LEN - 1));
    assign o_delta     = `DELTA_BITS'(dir_q * `DELTA_STEP);

    // phase_q counts the two setup cycles, then splits each sample into
    // a sample/advance cycle and a cycle covering the read register.
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q     <= S_WAIT;
            dir_q       <= '0;
            sample_q    <= '0;
            phase_q     <= 1'b0;
            acc_q       <= '0;
            scan_done_q <= 1'b0;
        end else begin
            case (state_q)
                S_WAIT: begin
                    if (i_frame_ready) begin
                        dir_q    <= '0;
                        sample_q <= '0;
                        phase_q  <= 1'b0;
                        acc_q    <= '0;
                        state_q  <= S_SETUP;
                    end
                end
                S_SETUP: begin
                    phase_q <= !phase_q;
                    if (phase_q) begin
                        state_q <= S_ACCUM;
                    end
                end
                S_ACCUM: begin
                    if (!phase_q) begin
                        acc_q <= acc_q + `POWER_BITS'(mag);
                        if (last_sample) begin
                            state_q <= S_EMIT;
                        end else begin
                            phase_q <= 1'b1;
                        end
                    end else begin
                        phase_q  <= 1'b0;
                        sample_q <= sample_q + 1'b1;
                    end
                end
                S_EMIT: begin
                    acc_q    <= '0;
                    sample_q <= '0;
                    if (last_dir) begin
                        scan_done_q <= 1'b1;
                        state_q     <= S_DONE;
                    end else begin
                        dir_q   <= dir_q + 1'b1;
                        state_q <= S_SETUP;
                    end
                end
                S_DONE: begin
                    scan_done_q <= 1'b0;
                    if (!i_frame_ready) begin
                        state_q <= S_WAIT;
                    end
                end
                default: begin
                    state_q <= S_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge i_50M_clk) begin
        if (state_q == S_ACCUM && !phase_q && last_sample) begin
            result_q.delta <= o_delta;
            result_q.power <= acc_q + `POWER_BITS'(mag);
        end
    end

    assign o_result       = result_q;
    assign o_result_valid = (state_q == S_EMIT);
    assign o_frame_done   = (state_q == S_EMIT) && last_dir;
    assign o_advance      = (state_q == S_ACCUM) && !phase_q;
    assign o_rewind       = (state_q == S_SETUP) && !phase_q;
    assign o_scan_done    = scan_done_q;

    // window reads are only meaningful while the buffer serves.
    a_advance_in_frame: assert property (
        @(posedge i_50M_clk) disable iff (i_rst) o_advance |-> i_frame_ready
    );

endmodule

`default_nettype wire

// File: design/ring_buffer.sv
////////////////////////////////////////
// Frame store with delayed-window reads.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "beam_cfg.svh"

module ring_buffer (
    input  logic                           i_50M_clk,
    input  logic                           i_rst,
    input  beam_pkg::pcm_sample_t          i_sample,
    input  logic [`DELTA_BITS-1:0]         i_delta,
    input  logic                           i_advance,
    input  logic                           i_rewind,
    input  logic                           i_scan_done,
    output logic signed [`SAMPLE_BITS-1:0] o_read_data,
    output logic                           o_frame_ready
);

    localparam int IDX_W = $clog2(`FRAME_LEN);
    localparam int POS_W = $clog2(`WIN_LEN);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_SERVE,
        S_CLEAR
    } buf_state_t;

    buf_state_t                     state_q;
    logic [IDX_W-1:0]               wr_ptr_q;
    logic [POS_W-1:0]               win_pos_q;
    logic [IDX_W-1:0]               rd_idx;
    logic                           write_en;
    logic                           last_write;
    logic signed [`SAMPLE_BITS-1:0] mem [`FRAME_LEN];
    logic signed [`SAMPLE_BITS-1:0] rd_data_q;

    // the first sample after reset is kept, it opens the frame.
    assign write_en   = i_sample.valid && (state_q == S_IDLE || state_q == S_FILL);
    assign last_write = write_en && (wr_ptr_q == IDX_W'(`FRAME_LEN - 1));
    assign rd_idx     = IDX_W'(i_delta) + IDX_W'(win_pos_q);

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            state_q   <= S_IDLE;
            wr_ptr_q  <= '0;
            win_pos_q <= '0;
        end else begin
            case (state_q)
                S_IDLE, S_FILL: begin
                    if (last_write) begin
                        wr_ptr_q <= '0;
                        state_q  <= S_SERVE;
                    end else if (write_en) begin
                        wr_ptr_q <= wr_ptr_q + 1'b1;
                        state_q  <= S_FILL;
                    end
                end
                S_SERVE: begin
                    if (i_scan_done) begin
                        win_pos_q <= '0;
                        state_q   <= S_CLEAR;
                    end else if (i_rewind) begin
                        win_pos_q <= '0;
                    end else if (i_advance && win_pos_q != POS_W'(`WIN_LEN - 1)) begin
                        win_pos_q <= win_pos_q + 1'b1;
                    end
                end
                S_CLEAR: begin
                    wr_ptr_q <= '0;
                    state_q  <= S_FILL;
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Storage is wiped in one cycle on CLEAR.
    always_ff @(posedge i_50M_clk) begin
        if (state_q == S_CLEAR) begin
            for (int i = 0; i < `FRAME_LEN; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            mem[wr_ptr_q] <= i_sample.data;
        end
        if (state_q == S_SERVE) begin
            rd_data_q <= mem[rd_idx];
        end
    end

    assign o_read_data   = rd_data_q;
    assign o_frame_ready = (state_q == S_SERVE);

    // the scanner's delay plus window position must stay inside the frame.
    a_rd_idx_range: assert property (
        @(posedge i_50M_clk) disable iff (i_rst)
        (state_q == S_SERVE) |-> (rd_idx <= IDX_W'(`FRAME_LEN - 1))
    );

    a_scan_done_in_serve: assert property (
        @(posedge i_50M_clk) disable iff (i_rst)
        i_scan_done |-> (state_q == S_SERVE)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the beam front end testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_beam_top \
    -o Vtb_beam_top

./obj_dir/Vtb_beam_top > sim.log
cat sim.log

# the run counts as passed only if the testbench printed its pass line.
if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/tb_beam_top.sv
////////////////////////////////////////
// Beam front end testbench: serial audio
// source, power model and result checks.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "beam_cfg.svh"

module tb_beam_top;

    import beam_pkg::*;

    localparam int HALF_BIT    = 4;
    localparam int EXTRA_BITS  = 2;
    localparam int N_FRAMES    = 3;
    localparam int CYCLE_LIMIT = N_FRAMES * (`FRAME_LEN * 2 * 52 * 4 + `N_DIR * 70) + 10000;

    logic         i_50M_clk;
    logic         i_rst;
    logic         i_start;
    logic         i_bclk;
    logic         i_lrck;
    logic         i_sdata;
    scan_result_t o_result;
    logic         o_result_valid;
    logic         o_frame_done;
    logic         o_frame_ready;

    logic [`SAMPLE_BITS-1:0] left_words  [`FRAME_LEN];
    logic [`SAMPLE_BITS-1:0] right_words [`FRAME_LEN];
    longint                  exp_power   [`N_DIR];
    logic [31:0]             lcg_state    = 32'hd775_d474;
    logic                    ready_prev   = 1'b0;
    int                      frame_no     = 0;
    int                      left_sent    = 0;
    int                      done_count   = 0;
    int                      result_total = 0;
    int                      dir_idx      = 0;
    int                      main_errs    = 0;
    int                      mon_errs     = 0;
    int                      assert_errs  = 0;
    int                      pass_count   = 0;
    int                      fail_count   = 0;
    int                      cycle_count  = 0;
    int                      f;

    beam_top UUT (
        .i_50M_clk      (i_50M_clk),
        .i_rst          (i_rst),
        .i_start        (i_start),
        .i_bclk         (i_bclk),
        .i_lrck         (i_lrck),
        .i_sdata        (i_sdata),
        .o_result       (o_result),
        .o_result_valid (o_result_valid),
        .o_frame_done   (o_frame_done),
        .o_frame_ready  (o_frame_ready)
    );

    initial begin
        i_50M_clk = 1'b0;
        forever #10 i_50M_clk = ~i_50M_clk;
    end

    always @(posedge i_50M_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the scan never finished", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // absolute value of a two's complement audio word.
    function automatic longint sample_magnitude(input logic [`SAMPLE_BITS-1:0] w);
        if (w[`SAMPLE_BITS-1]) begin
            return (longint'(1) << `SAMPLE_BITS) - longint'(w);
        end
        return longint'(w);
    endfunction

    function automatic longint window_power(input int delay);
        longint sum;
        int     k;
        sum = 0;
        for (k = 0; k < `WIN_LEN; k++) begin
            sum += sample_magnitude(left_words[delay + k]);
        end
        return sum;
    endfunction

    function automatic bit value_ok(input string name, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("Error: time %0t, %s = %0d, expected %0d", $time, name, got, exp);
        end
        return got == exp;
    endfunction

    function automatic int total_errors();
        return main_errs + mon_errs + assert_errs;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge i_50M_clk);
        #2;
    endtask

    // left-justified word, MSB first, lrck and data change while bclk is low.
    task automatic send_word(input logic right, input logic [`SAMPLE_BITS-1:0] word);
        logic [`SAMPLE_BITS-1:0] bits;
        int                      b;
        bits = word;
        for (b = `SAMPLE_BITS - 1; b >= 0; b--) begin
            i_lrck  = right;
            i_sdata = bits[`SAMPLE_BITS-1];
            i_bclk  = 1'b0;
            bits    = bits << 1;
            wait_cycles(HALF_BIT);
            i_bclk = 1'b1;
            if (b == 0 && !right) begin
                left_sent++;
            end
            wait_cycles(HALF_BIT);
        end
        for (b = 0; b < EXTRA_BITS; b++) begin
            i_sdata = 1'b0;
            i_bclk  = 1'b0;
            wait_cycles(HALF_BIT);
            i_bclk = 1'b1;
            wait_cycles(HALF_BIT);
        end
    endtask

    task automatic build_frame(input int fr);
        int i;
        int neg_idx;
        int pos_idx;
        int zero_idx;
        neg_idx  = (40 + 57 * fr) % `FRAME_LEN;
        pos_idx  = (30 + 33 * fr) % `FRAME_LEN;
        zero_idx = (75 + 12 * fr) % `FRAME_LEN;
        for (i = 0; i < `FRAME_LEN; i++) begin
            lcg_state      = lcg_next(lcg_state);
            left_words[i]  = lcg_state[31:8];
            lcg_state      = lcg_next(lcg_state);
            right_words[i] = lcg_state[31:8];
        end
        left_words[neg_idx]  = {1'b1, {(`SAMPLE_BITS-1){1'b0}}};
        left_words[pos_idx]  = {1'b0, {(`SAMPLE_BITS-1){1'b1}}};
        left_words[zero_idx] = '0;
        for (i = 0; i < `N_DIR; i++) begin
            exp_power[i] = window_power(i * `DELTA_STEP);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: fail, %0d errors", name, errs);
        end
    endtask

    task automatic check_quiet();
        int errs_before;
        int n;
        errs_before = total_errors();
        i_start = 1'b1;
        wait_cycles(1);
        i_start = 1'b0;
        for (n = 0; n < 40; n++) begin
            if (!value_ok("o_result_valid", longint'(o_result_valid), 0)) main_errs++;
            if (!value_ok("o_frame_done", longint'(o_frame_done), 0)) main_errs++;
            if (!value_ok("o_frame_ready", longint'(o_frame_ready), 0)) main_errs++;
            wait_cycles(1);
        end
        report_test("reset quiet", errs_before);
    endtask

    task automatic run_frame(input int fr);
        int errs_before;
        int i;
        errs_before = total_errors();
        build_frame(fr);
        frame_no  = fr;
        left_sent = 0;
        for (i = 0; i < `FRAME_LEN; i++) begin
            send_word(1'b0, left_words[i]);
            send_word(1'b1, right_words[i]);
        end
        while (done_count < fr + 1) begin
            wait_cycles(1);
        end
        // serial stream stays paused while the buffer clears.
        wait_cycles(10);
        if (!value_ok("o_frame_ready", longint'(o_frame_ready), 0)) main_errs++;
        if (!value_ok("result count", longint'(result_total), longint'(`N_DIR * (fr + 1)))) begin
            main_errs++;
        end
        report_test($sformatf("frame %0d", fr + 1), errs_before);
    endtask

    // results and frame_ready edges, sampled mid-cycle.
    always @(negedge i_50M_clk) begin
        if (!i_rst) begin
            if (o_frame_ready && !ready_prev) begin
                if (!value_ok("left words at frame ready", longint'(left_sent), `FRAME_LEN)) begin
                    mon_errs++;
                end
            end
            if (!o_frame_ready && ready_prev) begin
                if (!value_ok("frames done at ready fall", longint'(done_count),
                              longint'(frame_no + 1))) begin
                    mon_errs++;
                end
            end
            if (o_result_valid) begin
                dir_idx = result_total % `N_DIR;
                if (!value_ok("o_result.delta", longint'(o_result.delta),
                              longint'(dir_idx * `DELTA_STEP))) mon_errs++;
                if (!value_ok("o_result.power", longint'(o_result.power),
                              exp_power[dir_idx])) mon_errs++;
                if (!value_ok("o_frame_done", longint'(o_frame_done),
                              longint'(dir_idx == `N_DIR - 1))) mon_errs++;
                result_total++;
                if (o_frame_done) begin
                    done_count++;
                end
            end
            ready_prev = o_frame_ready;
        end
    end

    a_done_with_result: assert property (
        @(posedge i_50M_clk) disable iff (i_rst) o_frame_done |-> o_result_valid
    ) else begin
        $display("Error: time %0t, frame done pulse came without a result", $time);
        assert_errs++;
    end

    a_result_one_cycle: assert property (
        @(posedge i_50M_clk) disable iff (i_rst) o_result_valid |=> !o_result_valid
    ) else begin
        $display("Error: time %0t, result valid stayed high for two cycles", $time);
        assert_errs++;
    end

    a_result_in_frame: assert property (
        @(posedge i_50M_clk) disable iff (i_rst) o_result_valid |-> o_frame_ready
    ) else begin
        $display("Error: time %0t, result arrived while no frame was ready", $time);
        assert_errs++;
    end

    initial begin
        i_rst   = 1'b1;
        i_start = 1'b0;
        i_bclk  = 1'b0;
        i_lrck  = 1'b1;
        i_sdata = 1'b0;
        repeat (10) @(posedge i_50M_clk);
        #2;
        i_rst = 1'b0;
        wait_cycles(2);
        check_quiet();
        for (f = 0; f < N_FRAMES; f++) begin
            run_frame(f);
        end
        $display("tests passed %0d, failed %0d, errors %0d",
                 pass_count, fail_count, total_errors());
        if (fail_count == 0 && total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
